//--- uart_pkg.sv
package uart_pkg;

  // ******************************
  // frame format
  // ******************************

  localparam int cmd_width      = 16;
  localparam int data_bits      = 8;
  localparam int frame_bits     = 11; // start, 8 data, parity and stop.
  localparam int write_flag_bit = 15;

  // ******************************
  // command timing
  // ******************************

  localparam int gap_cycles         = 16; // idle clocks between the two frames of a write.
  localparam int reply_timeout_bits = 32;

  typedef enum logic [2:0] {
    idle,
    latch,
    send_hi,
    gap,
    send_lo,
    wait_reply,
    deliver
  } ctrl_state_e;

  // the parity bit makes the count of ones in data plus parity even.
  function automatic logic even_parity(input logic [data_bits-1:0] data);
    return ^data;
  endfunction

endpackage

//--- uart_serial_if.sv
`timescale 1ns/1ns

interface uart_serial_if;

  logic                           tx_start; // one-cycle request for a frame.
  logic [uart_pkg::data_bits-1:0] tx_data;
  logic                           tx_done;

  logic [uart_pkg::data_bits-1:0] rx_data;
  logic                           rx_valid;
  logic                           rx_err; // replaces rx_valid on a bad frame.

  modport ctrl (
    output tx_start,
    output tx_data,
    input  tx_done,
    input  rx_data,
    input  rx_valid,
    input  rx_err
  );

  modport tx_side (
    input  tx_start,
    input  tx_data,
    output tx_done
  );

  modport rx_side (
    output rx_data,
    output rx_valid,
    output rx_err
  );

endinterface

//--- uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic              clk,
  input  logic              rst_n,
  uart_serial_if.tx_side    sif,
  output logic              tx
);

  localparam int cnt_w   = $clog2(clks_per_bit);
  localparam int bit_w   = $clog2(uart_pkg::frame_bits);
  localparam int shift_w = uart_pkg::frame_bits - 1;

  logic               busy;
  logic [cnt_w-1:0]   clk_cnt;
  logic [bit_w-1:0]   bit_cnt;
  logic [shift_w-1:0] shreg; // data, parity and stop still to go out.
  logic               bit_end;
  logic               load;

  assign bit_end = busy && (clk_cnt == cnt_w'(clks_per_bit - 1));
  assign load    = sif.tx_start && !busy;

  // the stop bit is the last one, so its last cycle ends the frame.
  assign sif.tx_done = bit_end && (bit_cnt == bit_w'(uart_pkg::frame_bits - 1));

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shreg <= {1'b1, uart_pkg::even_parity(sif.tx_data), sif.tx_data};
    end
    else if (bit_end)
    begin
      shreg <= {1'b1, shreg[shift_w-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end
    else if (load)
    begin
      busy    <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx      <= 1'b0; // start bit.
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      if (sif.tx_done)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
        tx      <= shreg[0];
      end
    end
    else if (busy)
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
  parameter int clks_per_bit = 434
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rx,
  input  logic              rx_en,
  uart_serial_if.rx_side    sif
);

  localparam int cnt_w    = $clog2(clks_per_bit);
  localparam int bit_w    = $clog2(uart_pkg::frame_bits);
  localparam int shift_w  = uart_pkg::frame_bits - 1;
  localparam int half_bit = clks_per_bit / 2;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_frame
  } rx_state_e;

  rx_state_e          state;
  logic               rx_meta;
  logic               rx_sync;
  logic               rx_prev;
  logic [cnt_w-1:0]   clk_cnt;
  logic [bit_w-1:0]   bit_cnt;
  logic [shift_w-1:0] shreg;
  logic [shift_w-1:0] frame_next;
  logic               sample;
  logic               last_sample;
  logic               frame_ok;

  assign sample      = (state == rx_frame) && (clk_cnt == cnt_w'(clks_per_bit - 1));
  assign last_sample = sample && (bit_cnt == bit_w'(uart_pkg::frame_bits - 2));
  assign frame_next  = {rx_sync, shreg[shift_w-1:1]};

  // stop bit must be high and the parity bit must match the data.
  assign frame_ok = frame_next[shift_w-1] &&
                    (frame_next[uart_pkg::data_bits] ==
                     uart_pkg::even_parity(frame_next[uart_pkg::data_bits-1:0]));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      shreg <= frame_next;
    end
    if (last_sample)
    begin
      sif.rx_data <= frame_next[uart_pkg::data_bits-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= rx_idle;
      clk_cnt      <= '0;
      bit_cnt      <= '0;
      sif.rx_valid <= 1'b0;
      sif.rx_err   <= 1'b0;
    end
    else
    begin
      sif.rx_valid <= 1'b0;
      sif.rx_err   <= 1'b0;
      clk_cnt      <= clk_cnt + 1'b1;
      case (state)
        rx_idle:
        begin
          clk_cnt <= '0;
          if (rx_en && rx_prev && !rx_sync)
          begin
            state <= rx_start;
          end
        end
        rx_start:
        begin
          if (clk_cnt == cnt_w'(half_bit - 1))
          begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? rx_idle : rx_frame; // a short glitch is dropped.
          end
        end
        rx_frame:
        begin
          if (sample)
          begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
          end
          if (last_sample)
          begin
            state        <= rx_idle;
            sif.rx_valid <= frame_ok;
            sif.rx_err   <= !frame_ok;
          end
        end
        default:
        begin
          state <= rx_idle;
        end
      endcase
    end
  end

endmodule

//--- uart_cmd_ctrl.sv
`timescale 1ns/1ns

module uart_cmd_ctrl #(
  parameter int clks_per_bit = 434
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::cmd_width-1:0] cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic [uart_pkg::data_bits-1:0] read_data,
  output logic                           read_rdy,
  output logic                           rx_en,
  uart_serial_if.ctrl                    sif
);

  // a reply that starts just before the limit still has time to finish.
  localparam int timeout_bits = uart_pkg::reply_timeout_bits + uart_pkg::frame_bits;
  localparam int cnt_w        = $clog2(clks_per_bit);
  localparam int tbit_w       = $clog2(timeout_bits);
  localparam int gap_w        = $clog2(uart_pkg::gap_cycles);

  uart_pkg::ctrl_state_e          state;
  logic [uart_pkg::cmd_width-1:0] cmd_buf;
  logic [gap_w-1:0]               gap_cnt;
  logic [cnt_w-1:0]               wait_clk_cnt;
  logic [tbit_w-1:0]              wait_bit_cnt;
  logic                           gap_end;
  logic                           wait_bit_end;
  logic                           timeout;

  // deliver also accepts a new command, so cmd_rdy rises with read_rdy.
  assign cmd_rdy  = (state == uart_pkg::idle) || (state == uart_pkg::deliver);
  assign read_rdy = (state == uart_pkg::deliver);
  assign rx_en    = (state == uart_pkg::wait_reply);

  assign sif.tx_data = (state == uart_pkg::send_lo) ?
                       cmd_buf[uart_pkg::data_bits-1:0] :
                       cmd_buf[uart_pkg::cmd_width-1:uart_pkg::data_bits];

  assign gap_end      = (gap_cnt == gap_w'(uart_pkg::gap_cycles - 2));
  assign wait_bit_end = (wait_clk_cnt == cnt_w'(clks_per_bit - 1));
  assign timeout      = rx_en && wait_bit_end && (wait_bit_cnt == tbit_w'(timeout_bits - 1));

  // ******************************
  // command and reply registers
  // ******************************

  always_ff @(posedge clk)
  begin
    if (cmd_rdy && cmd_vld)
    begin
      cmd_buf <= cmd_in;
    end
    if (rx_en && sif.rx_valid)
    begin
      read_data <= sif.rx_data;
    end
  end

  // ******************************
  // gap and reply timers
  // ******************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gap_cnt      <= '0;
      wait_clk_cnt <= '0;
      wait_bit_cnt <= '0;
    end
    else
    begin
      gap_cnt <= (state == uart_pkg::gap) ? gap_cnt + 1'b1 : '0;
      if (!rx_en)
      begin
        wait_clk_cnt <= '0;
        wait_bit_cnt <= '0;
      end
      else if (wait_bit_end)
      begin
        wait_clk_cnt <= '0;
        wait_bit_cnt <= wait_bit_cnt + 1'b1;
      end
      else
      begin
        wait_clk_cnt <= wait_clk_cnt + 1'b1;
      end
    end
  end

  // ******************************
  // command FSM
  // ******************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= uart_pkg::idle;
      sif.tx_start <= 1'b0;
    end
    else
    begin
      sif.tx_start <= 1'b0;
      case (state)
        uart_pkg::idle, uart_pkg::deliver:
        begin
          state <= cmd_vld ? uart_pkg::latch : uart_pkg::idle;
        end
        uart_pkg::latch:
        begin
          state        <= uart_pkg::send_hi;
          sif.tx_start <= 1'b1;
        end
        uart_pkg::send_hi:
        begin
          if (sif.tx_done)
          begin
            state <= cmd_buf[uart_pkg::write_flag_bit] ? uart_pkg::gap : uart_pkg::wait_reply;
          end
        end
        uart_pkg::gap:
        begin
          if (gap_end)
          begin
            state        <= uart_pkg::send_lo;
            sif.tx_start <= 1'b1; // start bit follows the last gap cycle.
          end
        end
        uart_pkg::send_lo:
        begin
          if (sif.tx_done)
          begin
            state <= uart_pkg::idle;
          end
        end
        uart_pkg::wait_reply:
        begin
          if (sif.rx_valid)
          begin
            state <= uart_pkg::deliver;
          end
          else if (sif.rx_err || timeout)
          begin
            state <= uart_pkg::idle; // read ends without data.
          end
        end
        default:
        begin
          state <= uart_pkg::idle;
        end
      endcase
    end
  end

endmodule

//--- uart.sv
`timescale 1ns/1ns

module uart #(
  parameter int clks_per_bit = 434
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::cmd_width-1:0] cmd_in,
  input  logic                           cmd_vld,
  input  logic                           rx,
  output logic                           tx,
  output logic                           cmd_rdy,
  output logic                           read_rdy,
  output logic [uart_pkg::data_bits-1:0] read_data
);

  logic rx_en;

  uart_serial_if sif_i ();

  uart_cmd_ctrl #(
    .clks_per_bit (clks_per_bit)
  ) ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .rx_en     (rx_en),
    .sif       (sif_i.ctrl)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .sif   (sif_i.tx_side),
    .tx    (tx)
  );

  // the receiver only listens while a read waits for its reply.
  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) rx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .rx_en (rx_en),
    .sif   (sif_i.rx_side)
  );

endmodule

//--- uart_assertions.sv
`timescale 1ns/1ns

module uart_assertions (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy
);

  int fail_cnt = 0; // read by the testbench at the end of the run.

  // the line is idle and the master ready while reset is held and just after.
  assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> (cmd_rdy && tx))
  else
  begin
    $error("cmd_rdy or tx was low during or right after reset");
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy)
  else
  begin
    $error("cmd_rdy did not fall after an accepted command");
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
  else
  begin
    $error("read_rdy was high for more than one cycle");
    fail_cnt++;
  end

  // a ready master never has a frame on the line.
  assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
  else
  begin
    $error("tx was low while cmd_rdy was high");
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> !$past(cmd_rdy))
  else
  begin
    $error("read_rdy came while no read was in progress");
    fail_cnt++;
  end

endmodule

bind uart uart_assertions assert_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

//--- tb_uart.sv
`timescale 1ns/1ns

module tb_uart;

  localparam int clks_per_bit = 8;
  localparam int frame_cyc    = uart_pkg::frame_bits * clks_per_bit;
  localparam int write_cyc    = 2 * frame_cyc + uart_pkg::gap_cycles + 32;
  localparam int read_cyc     =
    (uart_pkg::reply_timeout_bits + uart_pkg::frame_bits + 2) * clks_per_bit;
  localparam int reply_good   = 0;
  localparam int reply_bad    = 1;
  localparam int reply_none   = 2;
  // reset and idle check, four writes and five reads with their settle times.
  localparam int watchdog_cycles = 1000 + 3 * frame_cyc + 4 * (write_cyc + 8 * clks_per_bit) +
                                   5 * (2 * frame_cyc + read_cyc + 8 * clks_per_bit);

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic [uart_pkg::cmd_width-1:0] cmd_in;
  logic                           cmd_vld;
  logic                           rx;
  logic                           tx;
  logic                           cmd_rdy;
  logic                           read_rdy;
  logic [7:0]                     read_data;

  int         seed = 32'h14bf;
  int         cyc = 0;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         rdy_cnt = 0;
  int         frame_end = 0; // cycle of the last decoded stop bit.
  logic [7:0] rdy_data; // read_data as seen during the read_rdy pulse.
  logic [7:0] frame_q[$];
  int         frame_start_q[$];

  uart #(
    .clks_per_bit (clks_per_bit)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      rdy_cnt++;
      rdy_data = read_data;
    end
  end

  // ******************************
  // serial slave model
  // ******************************

  initial
  begin : tx_model
    logic [uart_pkg::frame_bits-2:0] bits; // data, parity and stop.
    int                              start_cyc;
    int                              i;
    @(posedge rst_n);
    forever
    begin
      @(negedge tx);
      @(negedge clk);
      start_cyc = cyc;
      repeat (clks_per_bit / 2) @(negedge clk); // centre of the start bit.
      check_true(!tx, "start bit on tx was not low at its centre");
      for (i = 0; i < uart_pkg::frame_bits - 1; i++)
      begin
        repeat (clks_per_bit) @(negedge clk);
        bits[i] = tx;
      end
      check_eq("tx parity bit", 16'(bits[8]), 16'(^bits[7:0]));
      check_eq("tx stop bit", 16'(bits[9]), 16'h1);
      frame_q.push_back(bits[7:0]);
      frame_start_q.push_back(start_cyc);
      frame_end = cyc;
    end
  end

  task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
    else
    begin
      $display("error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic issue_cmd(input logic [15:0] cmd);
    frame_q.delete();
    frame_start_q.delete();
    rdy_cnt  = 0;
    rdy_data = 'x;
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_cmd_rdy(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    check_true(cmd_rdy, "cmd_rdy did not return high in time");
  endtask

  task automatic wait_frames(input int count, input int limit);
    int n;
    n = 0;
    while (frame_q.size() < count && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    check_true(frame_q.size() >= count, "no request frame appeared on tx");
  endtask

  // drives one reply frame on rx, LSB first, optionally with a wrong parity bit.
  task automatic send_reply(input logic [7:0] data, input logic bad_parity);
    logic [uart_pkg::frame_bits-1:0] frame;
    int                              i;
    frame = {1'b1, (^data) ^ bad_parity, data, 1'b0};
    for (i = 0; i < uart_pkg::frame_bits; i++)
    begin
      rx <= frame[i];
      repeat (clks_per_bit) @(posedge clk);
    end
  endtask

  task automatic run_write(input logic [15:0] cmd, input logic [15:0] other, input logic busy);
    issue_cmd(cmd);
    if (busy)
    begin
      repeat (3 * clks_per_bit) @(posedge clk);
      cmd_in  <= other; // arrives mid frame and must be dropped.
      cmd_vld <= 1'b1;
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
    wait_cmd_rdy(write_cyc);
    check_eq("tx frame count", 16'(frame_q.size()), 16'd2);
    repeat (4 * clks_per_bit) @(negedge clk);
    check_eq("tx frame count", 16'(frame_q.size()), 16'd2);
    if (frame_q.size() == 2)
    begin
      check_eq("tx high byte", 16'(frame_q[0]), 16'(cmd[15:8]));
      check_eq("tx low byte", 16'(frame_q[1]), 16'(cmd[7:0]));
      check_true(frame_start_q[1] - frame_start_q[0] - frame_cyc >= uart_pkg::gap_cycles,
                 "idle gap between the two write frames was too short");
    end
    check_eq("read_rdy pulse count", 16'(rdy_cnt), 16'd0);
  endtask

  task automatic run_read(input logic [15:0] cmd, input int mode);
    logic [7:0] reply;
    int         req_end;
    reply = ~cmd[15:8];
    issue_cmd(cmd);
    wait_frames(1, 2 * frame_cyc);
    req_end = frame_end;
    if (mode != reply_none)
    begin
      repeat (2 * clks_per_bit) @(posedge clk);
      send_reply(reply, mode == reply_bad);
    end
    wait_cmd_rdy(read_cyc);
    check_true(cyc - req_end <= read_cyc, "cmd_rdy came back too late after the request");
    repeat (4 * clks_per_bit) @(negedge clk);
    check_eq("tx frame count", 16'(frame_q.size()), 16'd1);
    if (frame_q.size() > 0)
      check_eq("tx request byte", 16'(frame_q[0]), 16'(cmd[15:8]));
    check_eq("read_rdy pulse count", 16'(rdy_cnt), (mode == reply_good) ? 16'd1 : 16'd0);
    if (mode == reply_good)
      check_eq("read_data", 16'(rdy_data), 16'(reply));
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
    end
  endtask

  initial
  begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  // ******************************
  // test sequence
  // ******************************

  initial
  begin : main
    int          err_start;
    logic [15:0] cmd;
    rst_n   = 1'b1;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    #1 rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    err_start = errors;
    @(negedge clk);
    check_eq("tx", 16'(tx), 16'h1);
    check_eq("cmd_rdy", 16'(cmd_rdy), 16'h1);
    check_eq("read_rdy", 16'(read_rdy), 16'h0);
    repeat (3 * frame_cyc) @(negedge clk);
    check_eq("tx frame count", 16'(frame_q.size()), 16'd0);
    check_eq("tx", 16'(tx), 16'h1);
    finish_test("reset state", err_start);

    err_start = errors;
    repeat (3)
    begin
      cmd = 16'($random(seed));
      cmd[uart_pkg::write_flag_bit] = 1'b1;
      run_write(cmd, 16'h0, 1'b0);
    end
    finish_test("write command", err_start);

    err_start = errors;
    repeat (3)
    begin
      cmd = 16'($random(seed));
      cmd[uart_pkg::write_flag_bit] = 1'b0;
      run_read(cmd, reply_good);
    end
    finish_test("read with good reply", err_start);

    err_start = errors;
    cmd = 16'($random(seed)) & 16'h7fff;
    run_read(cmd, reply_bad);
    finish_test("read with bad parity reply", err_start);

    err_start = errors;
    cmd = 16'($random(seed)) & 16'h7fff;
    run_read(cmd, reply_none);
    finish_test("read with no reply", err_start);

    err_start = errors;
    cmd = 16'($random(seed)) | 16'h8000;
    run_write(cmd, cmd ^ 16'h5a5a, 1'b1);
    finish_test("command ignored while busy", err_start);

    $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, dut_i.assert_i.fail_cnt);
    if (errors == 0 && dut_i.assert_i.fail_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- tb.f
uart_pkg.sv
uart_serial_if.sv
uart_tx.sv
uart_rx.sv
uart_cmd_ctrl.sv
uart.sv
uart_assertions.sv
tb_uart.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_uart -f tb.f -o sim_tb_uart

status=0
./obj_dir/sim_tb_uart +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation finished without failures"
